// ==== dv/tb_dcache_model.svh ====
// Data array reference model

`ifndef TB_DCACHE_MODEL_SVH
`define TB_DCACHE_MODEL_SVH

// Expected contents, one byte per way, set, word and lane
logic [7:0] model_mem [int];

function automatic int cell_key(input int way, input int set_idx, input int word_idx,
                                input int lane);
    return ((way * SETS + set_idx) * BLOCK_WORDS + word_idx) * 4 + lane;
endfunction

// A byte lands in lane offset, a half in the lane pair picked by offset bit 1
// and a word fills all lanes, always from the low bits of the data
function automatic void model_store(input int way, input int set_idx, input int word_idx,
                                    input store_width_t width, input logic [1:0] offset,
                                    input logic [31:0] data);
    int key;
    for (int lane = 0; lane < 4; lane++) begin
        key = cell_key(way, set_idx, word_idx, lane);
        if (width == STORE_BYTE && lane == int'(offset)) begin
            model_mem[key] = data[7:0];
        end else if (width == STORE_HALF && (lane / 2) == int'(offset[1])) begin
            model_mem[key] = 8'(data >> (8 * (lane % 2)));
        end else if (width == STORE_WORD) begin
            model_mem[key] = 8'(data >> (8 * lane));
        end
    end
endfunction

// Load result as the core expects it, a miss reads as zero
function automatic logic [31:0] expected_load(input int set_idx, input int word_idx,
                                              input load_op_t op, input logic [1:0] offset,
                                              input logic [WAYS-1:0] hit);
    logic [31:0]     value;
    logic [7:0]      b;
    logic [15:0]     h;
    logic [WAYS-1:0] mask;
    value = '0;
    for (int way = 0; way < WAYS; way++) begin
        mask = WAYS'(1) << way;
        if ((hit & mask) != '0) begin
            for (int lane = 0; lane < 4; lane++) begin
                value = value | (32'(model_mem[cell_key(way, set_idx, word_idx, lane)])
                                 << (8 * lane));
            end
        end
    end
    b = 8'(value >> (8 * int'(offset)));
    h = offset[1] ? value[31:16] : value[15:0];
    case (op)
        LOAD_BYTE:   return {{24{b[7]}}, b};
        LOAD_BYTE_U: return {24'h0, b};
        LOAD_HALF:   return {{16{h[15]}}, h};
        LOAD_HALF_U: return {16'h0, h};
        default:     return value;
    endcase
endfunction

`endif

// ==== dv/tb_dcache_data_array.sv ====
// Data array testbench

`timescale 1ns/1ps
`default_nettype none

module tb_dcache_data_array;

    import dcache_pkg::*;

    localparam int WAYS        = 2;
    localparam int BLOCK_WORDS = 4;
    localparam int SETS        = 16;
    localparam int WAY_IDX_W   = $clog2(WAYS);
    localparam int WORD_IDX_W  = $clog2(BLOCK_WORDS);
    localparam int SET_IDX_W   = $clog2(SETS);

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  store_valid_i;
    store_req_t            store_req_i;
    logic [WAY_IDX_W-1:0]  store_way_i;
    logic [SET_IDX_W-1:0]  store_set_i;
    logic [WORD_IDX_W-1:0] store_word_i;
    logic                  load_valid_i;
    load_req_t             load_req_i;
    logic [SET_IDX_W-1:0]  load_set_i;
    logic [WORD_IDX_W-1:0] load_word_i;
    logic [WAYS-1:0]       load_hit_way_i;
    logic                  load_valid_o;
    logic [WORD_WIDTH-1:0] load_data_o;

    // Expected load results by issue order, filled by the stimulus
    logic [31:0] expected_mem [int];
    int          issued = 0;
    int          answered = 0;
    int          checks = 0;
    int          errors = 0;
    int          stalls = 0;
    logic        valid_expected;
    string       test_name = "reset";
    load_op_t    op_list [5] = '{LOAD_BYTE, LOAD_BYTE_U, LOAD_HALF, LOAD_HALF_U, LOAD_WORD};
    logic [31:0] patterns [2] = '{32'h80FF_7F01, 32'h017F_FF80};

    `include "tb_dcache_model.svh"

    dcache_data_array #(
        .WAYS        (WAYS),
        .BLOCK_WORDS (BLOCK_WORDS),
        .SETS        (SETS)
    ) DUT (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #10 clk_i = ~clk_i;
        end
    end

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------

    // A load taken on an edge must show valid for exactly the next cycle
    always @(posedge clk_i or negedge rst_n_i) begin : valid_track
        if (!rst_n_i) begin
            valid_expected <= 1'b0;
        end else begin
            valid_expected <= load_valid_i;
        end
    end

    // Outputs are sampled mid cycle where they are settled
    always @(negedge clk_i) begin : result_check
        if (rst_n_i) begin
            checks++;
            valid_timing: assert (load_valid_o == valid_expected) else begin
                errors++;
                $display("Error: %s load_valid_o expected %b actual %b",
                         test_name, valid_expected, load_valid_o);
            end
            if (load_valid_o && answered >= issued) begin
                errors++;
                $display("A load result appeared in %s with no load outstanding", test_name);
            end else if (load_valid_o) begin
                checks++;
                load_value: assert (load_data_o == expected_mem[answered]) else begin
                    errors++;
                    $display("Error: %s load_data_o expected %h actual %h",
                             test_name, expected_mem[answered], load_data_o);
                end
                answered++;
            end
        end
    end

    // --------------------------------------------------
    // Stimulus tasks
    // --------------------------------------------------

    task automatic set_store(input int way, input int set_idx, input int word_idx,
                             input store_width_t width, input logic [1:0] offset,
                             input logic [31:0] data);
        store_valid_i           = 1'b1;
        store_req_i.width       = width;
        store_req_i.byte_offset = offset;
        store_req_i.data        = data;
        store_way_i             = WAY_IDX_W'(way);
        store_set_i             = SET_IDX_W'(set_idx);
        store_word_i            = WORD_IDX_W'(word_idx);
        model_store(way, set_idx, word_idx, width, offset, data);
    endtask

    // The expectation is taken before any store on the same edge updates the model
    task automatic set_load(input int set_idx, input int word_idx, input load_op_t op,
                            input logic [1:0] offset, input logic [WAYS-1:0] hit);
        load_valid_i           = 1'b1;
        load_req_i.op          = op;
        load_req_i.byte_offset = offset;
        load_set_i             = SET_IDX_W'(set_idx);
        load_word_i            = WORD_IDX_W'(word_idx);
        load_hit_way_i         = hit;
        expected_mem[issued]   = expected_load(set_idx, word_idx, op, offset, hit);
        issued++;
    endtask

    // Lets the next edge take the request, then drops the strobes
    task automatic cycle_end();
        @(posedge clk_i);
        #2;
        store_valid_i = 1'b0;
        load_valid_i  = 1'b0;
    endtask

    task automatic wait_for_loads();
        int cycles;
        cycles = 0;
        while (answered < issued && cycles < 20) begin
            cycle_end();
            cycles++;
        end
        if (answered < issued) begin
            stalls++;
            $display("Timeout in %s: %0d load results never came back",
                     test_name, issued - answered);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin : main_seq
        void'($urandom(38021));
        rst_n_i        = 1'b0;
        store_valid_i  = 1'b0;
        store_req_i    = '0;
        store_way_i    = '0;
        store_set_i    = '0;
        store_word_i   = '0;
        load_valid_i   = 1'b0;
        load_req_i     = '0;
        load_set_i     = '0;
        load_word_i    = '0;
        load_hit_way_i = '0;
        repeat (10) @(posedge clk_i);
        #2 rst_n_i = 1'b1;

        // Idle cycles keep valid low, then one missing load gives a single pulse
        test_name = "reset_idle";
        repeat (6) cycle_end();
        set_load(0, 0, LOAD_WORD, 2'd0, '0);
        cycle_end();
        wait_for_loads();

        // Fill every cell, then read all of it back one load per cycle
        test_name = "word_store_load";
        for (int i = 0; i < WAYS * SETS * BLOCK_WORDS; i++) begin
            set_store(i / (SETS * BLOCK_WORDS), (i / BLOCK_WORDS) % SETS,
                      i % BLOCK_WORDS, STORE_WORD, 2'($urandom()), $urandom());
            cycle_end();
        end
        for (int i = 0; i < WAYS * SETS * BLOCK_WORDS; i++) begin
            set_load((i / BLOCK_WORDS) % SETS, i % BLOCK_WORDS, LOAD_WORD,
                     2'($urandom()), WAYS'(1) << (i / (SETS * BLOCK_WORDS)));
            cycle_end();
        end
        wait_for_loads();

        test_name = "partial_store";
        for (int off = 0; off < 4; off++) begin
            set_store(1, 5, 2, STORE_BYTE, 2'(off), $urandom());
            cycle_end();
            set_load(5, 2, LOAD_WORD, 2'd0, 2'b10);
            cycle_end();
            set_store(0, 9, 3, STORE_HALF, 2'(off), $urandom());
            cycle_end();
            set_load(9, 3, LOAD_WORD, 2'd0, 2'b01);
            cycle_end();
        end
        wait_for_loads();

        // Both patterns mix lanes with the top bit set and clear
        test_name = "extend_load";
        for (int p = 0; p < 2; p++) begin
            set_store(p, 12, 1, STORE_WORD, 2'd0, patterns[p]);
            cycle_end();
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 5; k++) begin
                    set_load(12, 1, op_list[k], 2'(off), WAYS'(1) << p);
                    cycle_end();
                end
            end
        end
        wait_for_loads();

        test_name = "way_isolation";
        set_store(0, 7, 0, STORE_WORD, 2'd0, $urandom());
        cycle_end();
        set_load(7, 0, LOAD_WORD, 2'd0, 2'b10);
        cycle_end();
        set_load(7, 0, LOAD_WORD, 2'd0, 2'b00);
        cycle_end();
        wait_for_loads();

        // Same word on the same edge returns old data, the next load sees the new
        test_name = "store_load_collision";
        set_load(3, 2, LOAD_WORD, 2'd0, 2'b01);
        set_store(0, 3, 2, STORE_WORD, 2'd0, $urandom());
        cycle_end();
        set_load(3, 2, LOAD_WORD, 2'd0, 2'b01);
        set_store(0, 3, 2, STORE_BYTE, 2'd1, $urandom());
        cycle_end();
        set_load(3, 2, LOAD_BYTE_U, 2'd1, 2'b01);
        cycle_end();
        wait_for_loads();

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, stalls);
        if (errors != 0 || stalls != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule : tb_dcache_data_array

`default_nettype wire

// ==== flist.f ====
+incdir+dv
hw/dcache_pkg.sv
hw/data_memory_bank.sv
hw/dcache_way.sv
hw/store_formatter.sv
hw/load_aligner.sv
hw/dcache_data_array.sv
dv/tb_dcache_data_array.sv

// ==== hw/data_memory_bank.sv ====
// Byte writable cache bank

`timescale 1ns/1ps
`default_nettype none

module data_memory_bank #(
    parameter int SETS = 16,
    localparam int SET_IDX_W = $clog2(SETS)
) (
    input  logic                              clk_i,

    // Write port, driven by the store path
    input  logic                              write_i,
    input  logic [dcache_pkg::WORD_BYTES-1:0] byte_write_i,
    input  logic [SET_IDX_W-1:0]              write_address_i,
    input  logic [dcache_pkg::WORD_WIDTH-1:0] write_data_i,

    // Read port, driven by the load path
    input  logic                              read_i,
    input  logic [SET_IDX_W-1:0]              read_address_i,
    output logic [dcache_pkg::WORD_WIDTH-1:0] read_data_o
);

    import dcache_pkg::*;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------

    // One word per set, the array itself carries no reset
    logic [WORD_WIDTH-1:0] mem_q [SETS];

    // Only the enabled byte lanes of the addressed word change
    always_ff @(posedge clk_i) begin : write_port
        if (write_i) begin
            for (int lane = 0; lane < WORD_BYTES; lane++) begin
                if (byte_write_i[lane]) begin
                    mem_q[write_address_i][lane*BYTE_WIDTH +: BYTE_WIDTH] <=
                        write_data_i[lane*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end : write_port

    // The read samples the array before a write on the same edge lands,
    // so a colliding load sees the old word
    // Without a read strobe the output register holds its last value
    always_ff @(posedge clk_i) begin : read_port
        if (read_i) begin
            read_data_o <= mem_q[read_address_i];
        end
    end : read_port

endmodule : data_memory_bank

`default_nettype wire

// ==== hw/dcache_data_array.sv ====
// Data cache data array

`timescale 1ns/1ps
`default_nettype none

module dcache_data_array #(
    parameter int WAYS        = 2,
    parameter int BLOCK_WORDS = 4,
    parameter int SETS        = 16,
    localparam int WAY_IDX_W  = $clog2(WAYS),
    localparam int WORD_IDX_W = $clog2(BLOCK_WORDS),
    localparam int SET_IDX_W  = $clog2(SETS)
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    // Store request, written on the next edge
    input  logic                              store_valid_i,
    input  dcache_pkg::store_req_t            store_req_i,
    input  logic [WAY_IDX_W-1:0]              store_way_i,
    input  logic [SET_IDX_W-1:0]              store_set_i,
    input  logic [WORD_IDX_W-1:0]             store_word_i,

    // Load request, answered one cycle after the edge that takes it
    input  logic                              load_valid_i,
    input  dcache_pkg::load_req_t             load_req_i,
    input  logic [SET_IDX_W-1:0]              load_set_i,
    input  logic [WORD_IDX_W-1:0]             load_word_i,
    input  logic [WAYS-1:0]                   load_hit_way_i,

    output logic                              load_valid_o,
    output logic [dcache_pkg::WORD_WIDTH-1:0] load_data_o
);

    import dcache_pkg::*;

    // --------------------------------------------------
    // Store path
    // --------------------------------------------------

    logic [WORD_BYTES-1:0] byte_write;
    logic [WORD_WIDTH-1:0] write_data;

    store_formatter u_store_formatter (
        .store_req_i  (store_req_i),
        .byte_write_o (byte_write),
        .write_data_o (write_data)
    );

    // --------------------------------------------------
    // Ways
    // --------------------------------------------------

    // Per-way write strobe and the full block read from each way
    logic [WAYS-1:0]                                 way_write;
    logic [WAYS-1:0][BLOCK_WORDS-1:0][WORD_WIDTH-1:0] blocks;

    // Every way reads on each load, only the addressed way takes a store
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign way_write[w] = store_valid_i && (store_way_i == WAY_IDX_W'(w));

        dcache_way #(
            .SETS        (SETS),
            .BLOCK_WORDS (BLOCK_WORDS)
        ) u_way (
            .clk_i        (clk_i),
            .write_i      (way_write[w]),
            .byte_write_i (byte_write),
            .write_set_i  (store_set_i),
            .write_word_i (store_word_i),
            .write_data_i (write_data),
            .read_i       (load_valid_i),
            .read_set_i   (load_set_i),
            .block_o      (blocks[w])
        );
    end : g_way

    // --------------------------------------------------
    // Load path
    // --------------------------------------------------

    // Picks hit way and word from the registered blocks and extends the result
    load_aligner #(
        .WAYS        (WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_load_aligner (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .load_valid_i   (load_valid_i),
        .load_req_i     (load_req_i),
        .load_word_i    (load_word_i),
        .load_hit_way_i (load_hit_way_i),
        .blocks_i       (blocks),
        .load_valid_o   (load_valid_o),
        .load_data_o    (load_data_o)
    );

endmodule : dcache_data_array

`default_nettype wire

// ==== hw/dcache_pkg.sv ====
// Data cache shared definitions

`default_nettype none

package dcache_pkg;

    // --------------------------------------------------
    // Word geometry
    // --------------------------------------------------

    // Width of a data word, which is also the width of every bank port
    localparam int WORD_WIDTH = 32;

    // Width of one byte lane
    localparam int BYTE_WIDTH = 8;

    // Number of byte lanes in a word, one byte enable each
    localparam int WORD_BYTES = WORD_WIDTH / BYTE_WIDTH;

    // --------------------------------------------------
    // Access sizes
    // --------------------------------------------------

    // Store size, encoded like funct3[1:0] of the RISC-V store instructions
    typedef enum logic [1:0] {
        STORE_BYTE = 2'b00,
        STORE_HALF = 2'b01,
        STORE_WORD = 2'b10
    } store_width_t;

    // Load operation, encoded like funct3 of the RISC-V load instructions
    // Bit 2 set means the loaded value is zero extended
    typedef enum logic [2:0] {
        LOAD_BYTE   = 3'b000,
        LOAD_HALF   = 3'b001,
        LOAD_WORD   = 3'b010,
        LOAD_BYTE_U = 3'b100,
        LOAD_HALF_U = 3'b101
    } load_op_t;

    // --------------------------------------------------
    // Request bundles
    // --------------------------------------------------

    // Store request as it leaves the store unit
    // The data is right aligned, exactly as read from the register file
    typedef struct packed {
        store_width_t          width;
        logic [1:0]            byte_offset;
        logic [WORD_WIDTH-1:0] data;
    } store_req_t;

    // Load request control, carried alongside the bank read
    typedef struct packed {
        load_op_t   op;
        logic [1:0] byte_offset;
    } load_req_t;

endpackage : dcache_pkg

`default_nettype wire

// ==== hw/dcache_way.sv ====
// Data cache way

`timescale 1ns/1ps
`default_nettype none

module dcache_way #(
    parameter int SETS        = 16,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_IDX_W  = $clog2(SETS),
    localparam int WORD_IDX_W = $clog2(BLOCK_WORDS)
) (
    input  logic                                                clk_i,

    // Store side, already formatted into byte lanes
    input  logic                                                write_i,
    input  logic [dcache_pkg::WORD_BYTES-1:0]                   byte_write_i,
    input  logic [SET_IDX_W-1:0]                                write_set_i,
    input  logic [WORD_IDX_W-1:0]                               write_word_i,
    input  logic [dcache_pkg::WORD_WIDTH-1:0]                   write_data_i,

    // Load side, every bank of the way reads together
    input  logic                                                read_i,
    input  logic [SET_IDX_W-1:0]                                read_set_i,
    output logic [BLOCK_WORDS-1:0][dcache_pkg::WORD_WIDTH-1:0]  block_o
);

    // --------------------------------------------------
    // Write steering
    // --------------------------------------------------

    // One write enable per bank
    logic [BLOCK_WORDS-1:0] bank_write;

    // Only the bank holding the addressed word takes the store
    always_comb begin : word_decode
        bank_write = '0;
        bank_write[write_word_i] = write_i;
    end : word_decode

    // --------------------------------------------------
    // Banks
    // --------------------------------------------------

    // Bank w holds word w of every block in this way
    // Set index, byte enables and data are shared, the write enable is not
    // All banks read on the same edge so the whole block comes out at once
    for (genvar w = 0; w < BLOCK_WORDS; w++) begin : g_bank
        data_memory_bank #(
            .SETS (SETS)
        ) u_bank (
            .clk_i           (clk_i),
            .write_i         (bank_write[w]),
            .byte_write_i    (byte_write_i),
            .write_address_i (write_set_i),
            .write_data_i    (write_data_i),
            .read_i          (read_i),
            .read_address_i  (read_set_i),
            .read_data_o     (block_o[w])
        );
    end : g_bank

endmodule : dcache_way

`default_nettype wire

// ==== hw/load_aligner.sv ====
// Load result aligner

`timescale 1ns/1ps
`default_nettype none

module load_aligner #(
    parameter int WAYS        = 2,
    parameter int BLOCK_WORDS = 4,
    localparam int WORD_IDX_W = $clog2(BLOCK_WORDS)
) (
    input  logic                                                          clk_i,
    input  logic                                                          rst_n_i,

    // Load control, sampled on the same edge as the bank read
    input  logic                                                          load_valid_i,
    input  dcache_pkg::load_req_t                                         load_req_i,
    input  logic [WORD_IDX_W-1:0]                                         load_word_i,
    input  logic [WAYS-1:0]                                               load_hit_way_i,

    // Registered bank outputs of every way
    input  logic [WAYS-1:0][BLOCK_WORDS-1:0][dcache_pkg::WORD_WIDTH-1:0] blocks_i,

    output logic                                                          load_valid_o,
    output logic [dcache_pkg::WORD_WIDTH-1:0]                             load_data_o
);

    import dcache_pkg::*;

    localparam int HALF_WIDTH = 2 * BYTE_WIDTH;

    // --------------------------------------------------
    // Delayed load control
    // --------------------------------------------------

    logic                  valid_q;
    load_req_t             req_q;
    logic [WORD_IDX_W-1:0] word_q;
    logic [WAYS-1:0]       hit_q;

    // The valid flag lines up with the bank read data one cycle later
    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_reg
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_valid_i;
        end
    end : valid_reg

    // Request fields only change when a load is issued, like the banks
    always_ff @(posedge clk_i) begin : ctrl_reg
        if (load_valid_i) begin
            req_q  <= load_req_i;
            word_q <= load_word_i;
            hit_q  <= load_hit_way_i;
        end
    end : ctrl_reg

    assign load_valid_o = valid_q;

    // --------------------------------------------------
    // Way and word select
    // --------------------------------------------------

    logic [WORD_WIDTH-1:0] hit_word;
    logic [BYTE_WIDTH-1:0] byte_sel;
    logic [HALF_WIDTH-1:0] half_sel;

    // AND-OR mux over the one-hot hit vector, a miss gives zero
    always_comb begin : way_select
        hit_word = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_q[w]) begin
                hit_word = hit_word | blocks_i[w][word_q];
            end
        end
    end : way_select

    assign byte_sel = hit_word[req_q.byte_offset*BYTE_WIDTH +: BYTE_WIDTH];
    assign half_sel = req_q.byte_offset[1] ? hit_word[HALF_WIDTH +: HALF_WIDTH]
                                           : hit_word[0 +: HALF_WIDTH];

    // --------------------------------------------------
    // Extension
    // --------------------------------------------------

    // Signed ops copy the top bit of the slice, unsigned ops fill with zero
    always_comb begin : extend
        case (req_q.op)
            LOAD_BYTE:   load_data_o = {{(WORD_WIDTH-BYTE_WIDTH){byte_sel[BYTE_WIDTH-1]}},
                                        byte_sel};
            LOAD_BYTE_U: load_data_o = {{(WORD_WIDTH-BYTE_WIDTH){1'b0}}, byte_sel};
            LOAD_HALF:   load_data_o = {{(WORD_WIDTH-HALF_WIDTH){half_sel[HALF_WIDTH-1]}},
                                        half_sel};
            LOAD_HALF_U: load_data_o = {{(WORD_WIDTH-HALF_WIDTH){1'b0}}, half_sel};
            LOAD_WORD:   load_data_o = hit_word;
            default:     load_data_o = hit_word;
        endcase
    end : extend

endmodule : load_aligner

`default_nettype wire

// ==== hw/store_formatter.sv ====
// Store data formatter

`timescale 1ns/1ps
`default_nettype none

module store_formatter (
    input  dcache_pkg::store_req_t            store_req_i,
    output logic [dcache_pkg::WORD_BYTES-1:0] byte_write_o,
    output logic [dcache_pkg::WORD_WIDTH-1:0] write_data_o
);

    import dcache_pkg::*;

    // Width of a half word
    localparam int HALF_WIDTH = 2 * BYTE_WIDTH;

    // --------------------------------------------------
    // Source slices
    // --------------------------------------------------

    // Low byte and low half of the register value
    // A store never takes data from higher bits than its size
    logic [BYTE_WIDTH-1:0] store_byte;
    logic [HALF_WIDTH-1:0] store_half;

    assign store_byte = store_req_i.data[BYTE_WIDTH-1:0];
    assign store_half = store_req_i.data[HALF_WIDTH-1:0];

    // --------------------------------------------------
    // Lane placement
    // --------------------------------------------------

    // The data is replicated over the whole word so every lane already
    // carries the right value, and the byte enables alone pick the target
    // Offset bits finer than the store size are ignored
    always_comb begin : lane_format
        case (store_req_i.width)
            STORE_BYTE: begin
                // A single lane chosen by the full offset
                byte_write_o = WORD_BYTES'(1) << store_req_i.byte_offset;
                write_data_o = {WORD_BYTES{store_byte}};
            end

            STORE_HALF: begin
                // Upper or lower pair of lanes, offset bit 0 plays no part
                if (store_req_i.byte_offset[1]) begin
                    byte_write_o = 4'b1100;
                end else begin
                    byte_write_o = 4'b0011;
                end
                write_data_o = {2{store_half}};
            end

            STORE_WORD: begin
                // Every lane, no offset at all
                byte_write_o = '1;
                write_data_o = store_req_i.data;
            end

            default: begin
                // Unused encoding, the store writes nothing
                byte_write_o = '0;
                write_data_o = store_req_i.data;
            end
        endcase
    end : lane_format

endmodule : store_formatter

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps -f flist.f \
    --top-module tb_dcache_data_array -o tb_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
